//--- Makefile
BUILD_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -Wno-fatal --top-module fas_top_tb \
		-f files.f --Mdir $(BUILD_DIR) -o fas_top_tb
	./$(BUILD_DIR)/fas_top_tb

clean:
	rm -rf $(BUILD_DIR)

//--- design/fas_config.svh
`ifndef FAS_CONFIG_SVH
`define FAS_CONFIG_SVH

// FIR filter geometry
`define FIR_TAPS 32
`define FIR_HALF 16

// Rising edges after reset release until fir_valid
`define FIR_WARMUP 36

// FFT frame geometry and fixed point
`define FFT_POINTS 16
`define FFT_FRAC 8
`define TWIDDLE_FRAC 16

`endif

//--- design/fas_pkg.sv
`default_nettype none

`include "fas_config.svh"

package fas_pkg;

	typedef logic signed [15:0] sample_t;
	typedef logic signed [15:0] coef_t;
	typedef logic signed [16:0] pair_sum_t;
	typedef logic signed [31:0] product_t;
	typedef logic signed [23:0] twiddle_t;
	typedef logic signed [31:0] fft_word_t;
	typedef logic [31:0] bin_t; // {re[15:0], im[15:0]}

	// Symmetric half of the low-pass response from the outermost tap inward
	localparam coef_t fir_coefs [`FIR_HALF] = '{
		16'hff9e, 16'hff86, 16'hffa7, 16'h003b,
		16'h014b, 16'h024a, 16'h0222, 16'hffe4,
		16'hfbc5, 16'hf7ca, 16'hf74e, 16'hfd74,
		16'h0b1a, 16'h1dac, 16'h2f9e, 16'h3aa9
	};

	// W16^k = cos(2*pi*k/16) - j*sin(2*pi*k/16)
	localparam twiddle_t twiddle_re [`FFT_POINTS / 2] = '{
		24'h010000, 24'h00ec83, 24'h00b504, 24'h0061f7,
		24'h000000, 24'hff9e09, 24'hff4afc, 24'hff137d
	};

	localparam twiddle_t twiddle_im [`FFT_POINTS / 2] = '{
		24'h000000, 24'hff9e09, 24'hff4afc, 24'hff137d,
		24'hff0000, 24'hff137d, 24'hff4afc, 24'hff9e09
	};

endpackage

`default_nettype wire

//--- design/fas_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fas_config.svh"

module fas_top (
	input  wire logic             clk,
	input  wire logic             rst,
	input  wire fas_pkg::sample_t data,
	output fas_pkg::sample_t      fir_d,
	output logic                  fir_valid,
	output logic                  fft_valid,
	output fas_pkg::bin_t fft_d0, fft_d1, fft_d2, fft_d3,
	output fas_pkg::bin_t fft_d4, fft_d5, fft_d6, fft_d7,
	output fas_pkg::bin_t fft_d8, fft_d9, fft_d10, fft_d11,
	output fas_pkg::bin_t fft_d12, fft_d13, fft_d14, fft_d15
);

	fas_pkg::pair_sum_t pair_sum [`FIR_HALF];
	fas_pkg::product_t product [`FIR_HALF];

	fft_frame_if buf_frame ();
	fft_frame_if s8_frame ();
	fft_frame_if s4_frame ();
	fft_frame_if s2_frame ();
	fft_frame_if s1_frame ();

	// Four cycles from sample to fir_d
	fir_delay_line u_delay_line (
		.clk      (clk),
		.rst      (rst),
		.data     (data),
		.pair_sum (pair_sum)
	);

	fir_tap_multiply u_tap_multiply (
		.clk      (clk),
		.rst      (rst),
		.pair_sum (pair_sum),
		.product  (product)
	);

	fir_accumulate u_accumulate (
		.clk       (clk),
		.rst       (rst),
		.product   (product),
		.fir_d     (fir_d),
		.fir_valid (fir_valid)
	);

	fft_frame_buffer u_frame_buffer (
		.clk       (clk),
		.rst       (rst),
		.fir_d     (fir_d),
		.fir_valid (fir_valid),
		.frame     (buf_frame)
	);

	fft_butterfly_stage #(.SPAN(8)) u_stage8 (.clk(clk), .rst(rst),
		.in_frame(buf_frame), .out_frame(s8_frame));
	fft_butterfly_stage #(.SPAN(4)) u_stage4 (.clk(clk), .rst(rst),
		.in_frame(s8_frame), .out_frame(s4_frame));
	fft_butterfly_stage #(.SPAN(2)) u_stage2 (.clk(clk), .rst(rst),
		.in_frame(s4_frame), .out_frame(s2_frame));
	fft_butterfly_stage #(.SPAN(1)) u_stage1 (.clk(clk), .rst(rst),
		.in_frame(s2_frame), .out_frame(s1_frame));

	fft_output_reorder u_output_reorder (
		.clk       (clk),
		.rst       (rst),
		.in_frame  (s1_frame),
		.fft_valid (fft_valid),
		.fft_d0(fft_d0), .fft_d1(fft_d1), .fft_d2(fft_d2), .fft_d3(fft_d3),
		.fft_d4(fft_d4), .fft_d5(fft_d5), .fft_d6(fft_d6), .fft_d7(fft_d7),
		.fft_d8(fft_d8), .fft_d9(fft_d9), .fft_d10(fft_d10), .fft_d11(fft_d11),
		.fft_d12(fft_d12), .fft_d13(fft_d13), .fft_d14(fft_d14), .fft_d15(fft_d15)
	);

endmodule

`default_nettype wire

//--- design/fft_butterfly_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "fas_config.svh"

// Radix-2 DIF stage over groups of 2*SPAN points
module fft_butterfly_stage #(
	parameter int SPAN = 8
) (
	input  wire logic    clk,
	input  wire logic    rst,
	fft_frame_if.sink    in_frame,
	fft_frame_if.source  out_frame
);

	localparam int WORD_W = $bits(fas_pkg::fft_word_t);
	localparam int PROD_W = WORD_W + $bits(fas_pkg::twiddle_t);

	fas_pkg::fft_word_t nxt_re [`FFT_POINTS];
	fas_pkg::fft_word_t nxt_im [`FFT_POINTS];

	for (genvar p = 0; p < `FFT_POINTS; p++) begin : g_point
		localparam int OFS = p % (2 * SPAN);

		if (OFS < SPAN) begin : g_upper
			assign nxt_re[p] = in_frame.re[p] + in_frame.re[p + SPAN];
			assign nxt_im[p] = in_frame.im[p] + in_frame.im[p + SPAN];
		end else begin : g_lower
			// Twiddle exponent (n mod S) * 8 / S
			localparam int TW = (OFS - SPAN) * (`FFT_POINTS / 2) / SPAN;

			fas_pkg::fft_word_t dif_re;
			fas_pkg::fft_word_t dif_im;
			logic signed [PROD_W-1:0] prod_re;
			logic signed [PROD_W-1:0] prod_im;

			assign dif_re = in_frame.re[p - SPAN] - in_frame.re[p];
			assign dif_im = in_frame.im[p - SPAN] - in_frame.im[p];

			assign prod_re = dif_re * fas_pkg::twiddle_re[TW]
				- dif_im * fas_pkg::twiddle_im[TW];
			assign prod_im = dif_re * fas_pkg::twiddle_im[TW]
				+ dif_im * fas_pkg::twiddle_re[TW];

			// Drop the Q16 twiddle fraction
			assign nxt_re[p] = prod_re[`TWIDDLE_FRAC +: WORD_W];
			assign nxt_im[p] = prod_im[`TWIDDLE_FRAC +: WORD_W];
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			out_frame.valid <= 1'b0;
		end else begin
			out_frame.valid <= in_frame.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_frame.valid) begin
			for (int p = 0; p < `FFT_POINTS; p++) begin
				out_frame.re[p] <= nxt_re[p];
				out_frame.im[p] <= nxt_im[p];
			end
		end
	end

endmodule

`default_nettype wire

//--- design/fft_frame_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "fas_config.svh"

module fft_frame_buffer (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire fas_pkg::sample_t    fir_d,
	input  wire logic                fir_valid,
	fft_frame_if.source              frame
);

	localparam int IDX_W = $clog2(`FFT_POINTS);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`FFT_POINTS - 1);

	logic [IDX_W-1:0] wr_idx;
	fas_pkg::sample_t fill [`FFT_POINTS - 1]; // Last sample goes straight out

	function automatic fas_pkg::fft_word_t scale(input fas_pkg::sample_t s);
		return fas_pkg::fft_word_t'(s) <<< `FFT_FRAC;
	endfunction

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_idx <= '0;
			frame.valid <= 1'b0;
		end else begin
			frame.valid <= fir_valid && (wr_idx == LAST_IDX);
			if (fir_valid) begin
				wr_idx <= wr_idx + 1'b1; // Wraps to next frame
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fir_valid) begin
			if (wr_idx == LAST_IDX) begin
				for (int i = 0; i < `FFT_POINTS - 1; i++) begin
					frame.re[i] <= scale(fill[i]);
				end
				frame.re[`FFT_POINTS - 1] <= scale(fir_d);
				for (int i = 0; i < `FFT_POINTS; i++) begin
					frame.im[i] <= '0;
				end
			end else begin
				fill[wr_idx] <= fir_d;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/fft_frame_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "fas_config.svh"

// One complex frame held from its valid pulse until the next
interface fft_frame_if;

	logic valid;
	fas_pkg::fft_word_t re [`FFT_POINTS];
	fas_pkg::fft_word_t im [`FFT_POINTS];

	modport source (
		output valid,
		output re,
		output im
	);

	modport sink (
		input valid,
		input re,
		input im
	);

endinterface

`default_nettype wire

//--- design/fft_output_reorder.sv
`timescale 1ns/1ps
`default_nettype none

`include "fas_config.svh"

module fft_output_reorder (
	input  wire logic   clk,
	input  wire logic   rst,
	fft_frame_if.sink   in_frame,
	output logic        fft_valid,
	output fas_pkg::bin_t fft_d0, fft_d1, fft_d2, fft_d3,
	output fas_pkg::bin_t fft_d4, fft_d5, fft_d6, fft_d7,
	output fas_pkg::bin_t fft_d8, fft_d9, fft_d10, fft_d11,
	output fas_pkg::bin_t fft_d12, fft_d13, fft_d14, fft_d15
);

	localparam int IDX_W = $clog2(`FFT_POINTS);
	localparam int HALF_W = $bits(fas_pkg::bin_t) / 2;

	fas_pkg::bin_t bin_nxt [`FFT_POINTS];
	fas_pkg::bin_t bin_q [`FFT_POINTS];

	function automatic int bit_rev(input int k);
		int r;
		r = 0;
		for (int b = 0; b < IDX_W; b++) begin
			r = (r << 1) | ((k >> b) & 1);
		end
		return r;
	endfunction

	// DIF leaves bins in bit-reversed order
	for (genvar k = 0; k < `FFT_POINTS; k++) begin : g_bin
		localparam int SRC = bit_rev(k);
		assign bin_nxt[k] = {in_frame.re[SRC][`FFT_FRAC +: HALF_W],
			in_frame.im[SRC][`FFT_FRAC +: HALF_W]};
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			fft_valid <= 1'b0;
			for (int k = 0; k < `FFT_POINTS; k++) begin
				bin_q[k] <= '0;
			end
		end else begin
			fft_valid <= in_frame.valid;
			if (in_frame.valid) begin
				bin_q <= bin_nxt;
			end
		end
	end

	assign fft_d0 = bin_q[0];
	assign fft_d1 = bin_q[1];
	assign fft_d2 = bin_q[2];
	assign fft_d3 = bin_q[3];
	assign fft_d4 = bin_q[4];
	assign fft_d5 = bin_q[5];
	assign fft_d6 = bin_q[6];
	assign fft_d7 = bin_q[7];
	assign fft_d8 = bin_q[8];
	assign fft_d9 = bin_q[9];
	assign fft_d10 = bin_q[10];
	assign fft_d11 = bin_q[11];
	assign fft_d12 = bin_q[12];
	assign fft_d13 = bin_q[13];
	assign fft_d14 = bin_q[14];
	assign fft_d15 = bin_q[15];

endmodule

`default_nettype wire

//--- design/fir_accumulate.sv
`timescale 1ns/1ps
`default_nettype none

`include "fas_config.svh"

module fir_accumulate (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire fas_pkg::product_t   product [`FIR_HALF],
	output fas_pkg::sample_t         fir_d,
	output logic                     fir_valid
);

	localparam int GROUPS = 4;
	localparam int STRIDE = `FIR_HALF / GROUPS;
	localparam int CNT_W = $clog2(`FIR_WARMUP);
	localparam int PROD_W = $bits(fas_pkg::product_t);
	localparam int OUT_W = $bits(fas_pkg::sample_t);

	fas_pkg::product_t partial [GROUPS];
	fas_pkg::product_t total;
	logic [CNT_W-1:0] warm_cnt;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int g = 0; g < GROUPS; g++) begin
				partial[g] <= '0;
			end
			total <= '0;
			fir_d <= '0;
		end else begin
			for (int g = 0; g < GROUPS; g++) begin
				partial[g] <= product[g] + product[g + STRIDE]
					+ product[g + 2 * STRIDE] + product[g + 3 * STRIDE];
			end
			total <= partial[0] + partial[1] + partial[2] + partial[3];
			// Upper half nudged up by one for negative totals
			fir_d <= total[PROD_W-1 -: OUT_W] + {{(OUT_W - 1){1'b0}}, total[PROD_W-1]};
		end
	end

	// Sticky once the delay line has filled
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			warm_cnt <= '0;
			fir_valid <= 1'b0;
		end else if (!fir_valid) begin
			warm_cnt <= warm_cnt + 1'b1;
			if (warm_cnt == CNT_W'(`FIR_WARMUP - 1)) begin
				fir_valid <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/fir_delay_line.sv
`timescale 1ns/1ps
`default_nettype none

`include "fas_config.svh"

module fir_delay_line (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire fas_pkg::sample_t    data,
	output fas_pkg::pair_sum_t       pair_sum [`FIR_HALF]
);

	fas_pkg::sample_t taps [`FIR_TAPS];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < `FIR_TAPS; i++) begin
				taps[i] <= '0;
			end
		end else begin
			taps[0] <= data; // Newest sample
			for (int i = 1; i < `FIR_TAPS; i++) begin
				taps[i] <= taps[i - 1];
			end
		end
	end

	// Mirrored taps share a coefficient
	always_comb begin
		for (int i = 0; i < `FIR_HALF; i++) begin
			pair_sum[i] = fas_pkg::pair_sum_t'(taps[i])
				+ fas_pkg::pair_sum_t'(taps[`FIR_TAPS - 1 - i]);
		end
	end

endmodule

`default_nettype wire

//--- design/fir_tap_multiply.sv
`timescale 1ns/1ps
`default_nettype none

`include "fas_config.svh"

module fir_tap_multiply (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire fas_pkg::pair_sum_t  pair_sum [`FIR_HALF],
	output fas_pkg::product_t        product [`FIR_HALF]
);

	fas_pkg::product_t prod_nxt [`FIR_HALF];

	// Full 32-bit signed products that wrap on overflow
	always_comb begin
		for (int i = 0; i < `FIR_HALF; i++) begin
			prod_nxt[i] = fas_pkg::product_t'(pair_sum[i])
				* fas_pkg::product_t'(fas_pkg::fir_coefs[i]);
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < `FIR_HALF; i++) begin
				product[i] <= '0;
			end
		end else begin
			for (int i = 0; i < `FIR_HALF; i++) begin
				product[i] <= prod_nxt[i];
			end
		end
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+design
design/fas_pkg.sv
design/fft_frame_if.sv
design/fir_delay_line.sv
design/fir_tap_multiply.sv
design/fir_accumulate.sv
design/fft_frame_buffer.sv
design/fft_butterfly_stage.sv
design/fft_output_reorder.sv
design/fas_top.sv
tb/fas_top_tb.sv

//--- tb/fas_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fas_config.svh"

module fas_top_tb;

	localparam int ROWS = 8;
	localparam int SETTLE = 40;
	localparam int PULSE_GAP = 16;

	// Symmetric coefficient half from the outermost tap inward
	localparam logic signed [15:0] coefs [`FIR_HALF] = '{
		16'hff9e, 16'hff86, 16'hffa7, 16'h003b, 16'h014b, 16'h024a, 16'h0222, 16'hffe4,
		16'hfbc5, 16'hf7ca, 16'hf74e, 16'hfd74, 16'h0b1a, 16'h1dac, 16'h2f9e, 16'h3aa9
	};

	logic clk;
	logic rst;
	fas_pkg::sample_t data;
	fas_pkg::sample_t fir_d;
	logic fir_valid;
	logic fft_valid;
	fas_pkg::bin_t fft_d [`FFT_POINTS];

	string row_name [ROWS];
	int row_amp [ROWS][4];
	fas_pkg::sample_t row_fir [ROWS][4]; // Steady fir_d per phase of the newest tap

	string cur_name;
	int cur;
	int edge_cnt;
	int row_cycles;
	int last_pulse;
	logic fir_seen;
	int unsigned lcg_state;

	fas_top DUT (
		.clk(clk), .rst(rst), .data(data),
		.fir_d(fir_d), .fir_valid(fir_valid), .fft_valid(fft_valid),
		.fft_d0(fft_d[0]), .fft_d1(fft_d[1]), .fft_d2(fft_d[2]), .fft_d3(fft_d[3]),
		.fft_d4(fft_d[4]), .fft_d5(fft_d[5]), .fft_d6(fft_d[6]), .fft_d7(fft_d[7]),
		.fft_d8(fft_d[8]), .fft_d9(fft_d[9]), .fft_d10(fft_d[10]), .fft_d11(fft_d[11]),
		.fft_d12(fft_d[12]), .fft_d13(fft_d[13]), .fft_d14(fft_d[14]), .fft_d15(fft_d[15])
	);

	always #4 clk = ~clk;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_sample(input string name, input fas_pkg::sample_t exp,
		input fas_pkg::sample_t act);
		if (act !== exp) begin
			fail_run($sformatf("error: %s expected %0d actual %0d", name, exp, act));
		end
	endtask

	task automatic check_bin(input string name, input fas_pkg::bin_t exp,
		input fas_pkg::bin_t act);
		if (act !== exp) begin
			fail_run($sformatf("error: %s expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			fail_run($sformatf("error: %s expected %b actual %b", name, exp, act));
		end
	endtask

	function automatic int unsigned lcg_next(input int unsigned s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Newest tap holds phase p of a period-4 input
	function automatic fas_pkg::sample_t fir_model(input int amp [4], input int p);
		int total;
		total = 0;
		for (int i = 0; i < `FIR_HALF; i++) begin
			total += (amp[(p + 64 - i) % 4] + amp[(p + 1 + i) % 4]) * int'(coefs[i]);
		end
		return fas_pkg::sample_t'(total >>> 16) + ((total < 0) ? 16'sd1 : 16'sd0);
	endfunction

	// Exact DFT of a 16-point frame repeating y with powers of -j as twiddles
	function automatic fas_pkg::bin_t dft_model(input fas_pkg::sample_t y [4], input int k);
		int re;
		int im;
		re = 0;
		im = 0;
		if (k % 4 == 0) begin
			for (int n = 0; n < `FFT_POINTS; n++) begin
				case ((n * k / 4) % 4)
					0: re += y[n % 4];
					1: im -= y[n % 4];
					2: re -= y[n % 4];
					default: im += y[n % 4];
				endcase
			end
		end
		return {re[15:0], im[15:0]};
	endfunction

	task automatic build_table();
		row_name[0] = "const_pos";
		row_amp[0] = '{200, 200, 200, 200};
		row_name[1] = "const_neg";
		row_amp[1] = '{-350, -350, -350, -350};
		row_name[2] = "alt_period2";
		row_amp[2] = '{250, -250, 250, -250};
		row_name[3] = "period4";
		row_amp[3] = '{300, 120, -180, 40};
		for (int r = 4; r < ROWS; r++) begin
			row_name[r] = $sformatf("lcg_%0d", r - 4);
			for (int i = 0; i < 4; i++) begin
				lcg_state = lcg_next(lcg_state);
				row_amp[r][i] = int'((lcg_state >> 16) % 1023) - 511;
			end
		end
		for (int r = 0; r < ROWS; r++) begin
			for (int p = 0; p < 4; p++) begin
				row_fir[r][p] = fir_model(row_amp[r], p);
			end
		end
	endtask

	task automatic drive_input();
		if (cur >= 0) begin
			data = fas_pkg::sample_t'(row_amp[cur][(edge_cnt + 1) % 4]); // Edge e takes phase e
		end else begin
			data = '0;
		end
	endtask

	// One clock with checks and the next input at the falling edge
	task automatic step();
		@(posedge clk);
		edge_cnt++;
		@(negedge clk);
		row_cycles++;
		if (fft_valid) begin
			if (last_pulse >= 0 && edge_cnt - last_pulse != PULSE_GAP) begin
				fail_run($sformatf("error: %s fft_valid gap expected %0d actual %0d",
					cur_name, PULSE_GAP, edge_cnt - last_pulse));
			end
			last_pulse = edge_cnt;
		end
		if (fir_seen) begin
			check_flag({cur_name, " fir_valid"}, 1'b1, fir_valid);
		end
		if (cur >= 0 && row_cycles >= SETTLE) begin
			check_sample({cur_name, " fir_d"}, row_fir[cur][(edge_cnt - 4) % 4], fir_d);
		end
		drive_input();
	endtask

	task automatic wait_pulse();
		int n;
		n = 0;
		step();
		while (!fft_valid) begin
			n++;
			if (n > 2 * PULSE_GAP) begin
				fail_run($sformatf("%s: timed out waiting for fft_valid", cur_name));
			end
			step();
		end
	endtask

	task automatic check_idle(input string name);
		check_flag({name, " fir_valid"}, 1'b0, fir_valid);
		check_flag({name, " fft_valid"}, 1'b0, fft_valid);
		check_sample({name, " fir_d"}, '0, fir_d);
		for (int k = 0; k < `FFT_POINTS; k++) begin
			check_bin($sformatf("%s bin %0d", name, k), '0, fft_d[k]);
		end
	endtask

	// Frame sample 0 left the FIR 21 edges before fft_valid and entered it 4 edges earlier
	task automatic check_frame();
		fas_pkg::sample_t y [4];
		for (int j = 0; j < 4; j++) begin
			y[j] = row_fir[cur][(edge_cnt - 25 + j) % 4];
		end
		for (int k = 0; k < `FFT_POINTS; k++) begin
			check_bin($sformatf("%s bin %0d", cur_name, k), dft_model(y, k), fft_d[k]);
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		data = '0;
		cur = -1;
		cur_name = "reset";
		edge_cnt = 0;
		row_cycles = 0;
		last_pulse = -1;
		fir_seen = 1'b0;
		lcg_state = 27;
		build_table();
		for (int i = 0; i < 16; i++) begin
			step();
			check_idle("reset");
		end
		rst = 1'b0;
		cur_name = "warmup";
		for (int e = 1; e <= `FIR_WARMUP; e++) begin
			step();
			if (e == 1) begin
				check_idle("after reset");
			end
			check_flag($sformatf("warmup edge %0d fir_valid", e), e == `FIR_WARMUP, fir_valid);
		end
		fir_seen = 1'b1;
		for (int r = 0; r < ROWS; r++) begin
			cur = r;
			cur_name = row_name[r];
			row_cycles = 0;
			drive_input();
			for (int c = 0; c < SETTLE; c++) begin
				step();
			end
			for (int p = 0; p < 3; p++) begin
				wait_pulse();
			end
			check_frame();
		end
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire
